/* usbCtrlPkg.sv */
package usbCtrlPkg;

  // endpoint 0 sizing
  localparam int MAX_PKT  = 8;                   // full-speed ep0 packet size
  localparam int DATA_W   = 8 * MAX_PKT;         // one packet as a flat word
  localparam int NBYTES_W = $clog2(MAX_PKT) + 1; // 0..MAX_PKT inclusive

  // device identity, placeholders until a real pair is allocated
  localparam logic [15:0] VENDOR_ID  = 16'h1337;
  localparam logic [15:0] PRODUCT_ID = 16'hf055;

  // descriptor lengths, both must stay under 128 bytes
  localparam int DEVICE_BLENGTH      = 18;
  localparam int CONFIG_WTOTALLENGTH = 9 + 9 + 7 + 7; // config, iface, two eps

  // bDescriptorType codes
  localparam logic [7:0] DESC_DEVICE    = 8'd1;
  localparam logic [7:0] DESC_CONFIG    = 8'd2;
  localparam logic [7:0] DESC_INTERFACE = 8'd4;
  localparam logic [7:0] DESC_ENDPOINT  = 8'd5;

  // standard bRequest codes handled here
  localparam logic [7:0] REQ_SET_ADDRESS    = 8'd5;
  localparam logic [7:0] REQ_GET_DESCRIPTOR = 8'd6;

  // class and endpoint attribute codes
  localparam logic [7:0] CLASS_UNKNOWN = 8'd0;   // class given per interface
  localparam logic [7:0] CLASS_VENDOR  = 8'd255; // usbserial binds on vid:pid
  localparam logic [7:0] EP_BULK       = 8'd2;

  // transaction the bus side is running right now
  typedef struct packed {
    logic setup;
    logic out;
    logic in;
  } txnType_t;

  // setup packet, byte 0 sits in the low bits
  typedef struct packed {
    logic [15:0] wLength;
    logic [15:0] wIndex;
    logic [15:0] wValue;   // high byte is descriptor type for GET_DESCRIPTOR
    logic [7:0]  bRequest;
    logic        direction; // 1 = device to host
    logic [1:0]  reqType;   // standard, class, vendor
    logic [4:0]  recipient;
  } setupPkt_t;

  // one receive word, setup fields or raw bytes depending on the stage
  typedef union packed {
    setupPkt_t       setup;
    logic [7:0][7:0] bytes;
  } er0Word_u;

  typedef struct packed {
    logic                valid;
    er0Word_u            data;
    logic [NBYTES_W-1:0] nBytes;
  } epRx_t;

  typedef struct packed {
    logic                valid;
    logic [DATA_W-1:0]   data;
    logic [NBYTES_W-1:0] nBytes;
  } epTx_t;

  // control transfer stage, at most one set
  typedef struct packed {
    logic noData;
    logic read;
    logic write;
  } tfrFlags_t;

  // request captured when the setup stage is accepted
  typedef struct packed {
    logic       isSetAddress;
    logic       descDevice;  // device rather than config descriptor
    logic [6:0] newAddr;
    logic [7:0] reqLen;      // low byte of wLength
  } reqInfo_t;

endpackage

/* ctrlStageTracker.sv */
module ctrlStageTracker import usbCtrlPkg::*; (
  input  logic      i_clk,
  input  logic      i_rstN,
  input  txnType_t  i_txnType,
  input  epRx_t     i_er0,
  input  logic      i_et0Ready,   // high for the cycle the host ACK arrives
  input  epTx_t     i_et0,
  output logic      o_er0Ready,
  output logic      o_er0Stall,
  output logic      o_et0Stall,
  output logic      o_begin,
  output logic      o_statusDone,
  output tfrFlags_t o_flags,
  output reqInfo_t  o_req
);

  setupPkt_t setupPkt;
  logic      er0Accepted;
  logic      et0Accepted;
  logic      beginTfr;
  logic      rcvdZlpOut;
  logic      sentZlpIn;
  logic      isSetAddress;
  logic      isGetDesc;
  logic      descDevice;
  logic      supported;
  logic      hasData;
  tfrFlags_t raise;
  tfrFlags_t lower;
  tfrFlags_t flagsQ;
  logic      er0StallQ;
  logic      et0StallQ;
  reqInfo_t  reqQ;

  assign setupPkt    = i_er0.data.setup;                 // setup view of the rx word
  assign er0Accepted = o_er0Ready && i_er0.valid;
  assign et0Accepted = i_et0Ready && i_et0.valid;
  assign beginTfr    = i_txnType.setup && er0Accepted;  // setup ACKed, transfer starts
  assign rcvdZlpOut  = i_txnType.out && er0Accepted && (i_er0.nBytes == '0); // status OUT
  assign sentZlpIn   = i_txnType.in && et0Accepted && (i_et0.nBytes == '0);

  // request decode, only valid in the begin cycle
  assign isSetAddress = (setupPkt.bRequest == REQ_SET_ADDRESS);
  assign isGetDesc    = (setupPkt.bRequest == REQ_GET_DESCRIPTOR);
  assign descDevice   = (setupPkt.wValue[15:8] == DESC_DEVICE);
  assign supported    = isSetAddress ||
                        (isGetDesc && (descDevice || setupPkt.wValue[15:8] == DESC_CONFIG));
  assign hasData      = (setupPkt.wLength != '0);

  // an unsupported data stage gets a stall instead of a stage flag
  assign raise.noData = beginTfr && !hasData;
  assign raise.read   = beginTfr && hasData && setupPkt.direction && supported;
  assign raise.write  = beginTfr && hasData && !setupPkt.direction && supported;

  // host may abandon a transfer at any point, a new setup wins
  assign lower.noData = sentZlpIn || et0StallQ || beginTfr;
  assign lower.read   = rcvdZlpOut || et0StallQ || beginTfr;
  assign lower.write  = sentZlpIn || er0StallQ || beginTfr;

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      flagsQ <= '0;
    end else begin
      flagsQ <= raise | (flagsQ & ~lower); // raise has priority over begin lowering
    end
  end

  // stall holds until the next setup, the bus side cannot tell when it went out
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      et0StallQ <= 1'b0;
      er0StallQ <= 1'b0;
    end else if (beginTfr) begin
      et0StallQ <= hasData && setupPkt.direction && !supported;
      er0StallQ <= hasData && !setupPkt.direction && !supported;
    end
  end

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      reqQ <= '0;
    end else if (beginTfr) begin
      reqQ.isSetAddress <= isSetAddress;
      reqQ.descDevice   <= descDevice;
      reqQ.newAddr      <= setupPkt.wValue[6:0];
      reqQ.reqLen       <= setupPkt.wLength[7:0];  // descriptors are short
    end
  end

  // ACK every setup, plus the zero-length status OUT of a read
  assign o_er0Ready   = i_txnType.setup || flagsQ.read;
  assign o_er0Stall   = er0StallQ;
  assign o_et0Stall   = et0StallQ;
  assign o_begin      = beginTfr;
  assign o_statusDone = sentZlpIn && flagsQ.noData; // status IN of a no-data transfer
  assign o_flags      = flagsQ;
  assign o_req        = reqQ;

  flagsOnehot: assert property (@(posedge i_clk) disable iff (!i_rstN)
    $onehot0({flagsQ.noData, flagsQ.read, flagsQ.write}));

  stallNotValid: assert property (@(posedge i_clk) disable iff (!i_rstN)
    (er0StallQ || et0StallQ) |-> !i_et0.valid);

endmodule

/* descriptorRom.sv */
module descriptorRom import usbCtrlPkg::*; (
  input  logic              i_descDevice,
  input  logic [1:0]        i_pktIdx,
  output logic [DATA_W-1:0] o_slice,
  output logic [6:0]        o_descLen
);

  localparam int ROM_BYTES = 4 * MAX_PKT; // one slot per packet index

  logic [0:ROM_BYTES-1][7:0] devRom;  // index 0 is byte 0 on the wire
  logic [0:ROM_BYTES-1][7:0] cfgRom;

  // device descriptor, multi-byte fields little endian
  assign devRom = {
    8'(DEVICE_BLENGTH),                       // bLength
    DESC_DEVICE,                              // bDescriptorType
    8'h00, 8'h02,                             // bcdUSB 2.00
    CLASS_UNKNOWN,                            // bDeviceClass, see interface
    8'h00,                                    // bDeviceSubClass
    8'h00,                                    // bDeviceProtocol
    8'(MAX_PKT),                              // bMaxPacketSize0
    VENDOR_ID[7:0], VENDOR_ID[15:8],          // idVendor
    PRODUCT_ID[7:0], PRODUCT_ID[15:8],        // idProduct
    8'h00, 8'h00,                             // bcdDevice
    8'h00,                                    // iManufacturer, no strings
    8'h00,                                    // iProduct
    8'h00,                                    // iSerialNumber
    8'h01,                                    // bNumConfigurations
    {(ROM_BYTES - DEVICE_BLENGTH){8'h00}}     // pad to the slot count
  };

  // configuration set, returned whole
  assign cfgRom = {
    8'd9,                                     // bLength
    DESC_CONFIG,
    8'(CONFIG_WTOTALLENGTH), 8'h00,           // wTotalLength
    8'd1,                                     // bNumInterfaces
    8'd1,                                     // bConfigurationValue
    8'd0,                                     // iConfiguration
    8'hC0,                                    // bus and self powered
    8'd50,                                    // bMaxPower 100 mA
    8'd9,                                     // interface bLength
    DESC_INTERFACE,
    8'd0,                                     // bInterfaceNumber
    8'd0,                                     // bAlternateSetting
    8'd2,                                     // bNumEndpoints
    CLASS_VENDOR,                             // bInterfaceClass
    8'd0,                                     // bInterfaceSubClass
    8'd0,                                     // bInterfaceProtocol
    8'd0,                                     // iInterface
    8'd7,                                     // ep bLength
    DESC_ENDPOINT,
    8'h81,                                    // EP1 IN, device tx
    EP_BULK,
    8'(MAX_PKT), 8'h00,                       // wMaxPacketSize
    8'd0,                                     // bInterval, ignored for bulk
    8'd7,
    DESC_ENDPOINT,
    8'h01,                                    // EP1 OUT, device rx
    EP_BULK,
    8'(MAX_PKT), 8'h00,
    8'd0
  };

  // byte b of the packet goes to bits 8b+7:8b
  always_comb begin
    for (int b = 0; b < MAX_PKT; b++) begin
      o_slice[8*b +: 8] = i_descDevice ? devRom[i_pktIdx*MAX_PKT + b] :
                                         cfgRom[i_pktIdx*MAX_PKT + b];
    end
  end

  assign o_descLen = i_descDevice ? 7'(DEVICE_BLENGTH) : 7'(CONFIG_WTOTALLENGTH);

endmodule

/* descriptorSender.sv */
module descriptorSender import usbCtrlPkg::*; (
  input  logic      i_clk,
  input  logic      i_rstN,
  input  logic      i_begin,
  input  tfrFlags_t i_flags,
  input  reqInfo_t  i_req,
  input  logic      i_et0Ready,
  output epTx_t     o_et0
);

  logic [2:0]        pktCnt;     // full packets sent, 4 at most
  logic              lastSent;   // short or zero-length packet went out
  logic [DATA_W-1:0] slice;
  logic [6:0]        descLen;
  logic [7:0]        sendLen;
  logic [7:0]        sentBytes;
  logic [7:0]        remaining;
  logic              fullPkt;
  logic              et0Accepted;

  descriptorRom uDescRom (
    .i_descDevice (i_req.descDevice),
    .i_pktIdx     (pktCnt[1:0]),        // wraps only for the trailing zlp
    .o_slice      (slice),
    .o_descLen    (descLen)
  );

  // host may ask for less than the whole descriptor
  assign sendLen     = ({1'b0, descLen} < i_req.reqLen) ? {1'b0, descLen} : i_req.reqLen;
  assign sentBytes   = 8'(pktCnt * MAX_PKT);
  assign remaining   = sendLen - sentBytes;
  assign fullPkt     = (remaining >= 8'(MAX_PKT));
  assign et0Accepted = i_et0Ready && o_et0.valid;

  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      pktCnt   <= '0;
      lastSent <= 1'b0;
    end else if (i_begin) begin
      pktCnt   <= '0;
      lastSent <= 1'b0;
    end else if (et0Accepted && i_flags.read) begin
      if (fullPkt) begin
        pktCnt <= pktCnt + 3'd1;
      end else begin
        lastSent <= 1'b1;   // short packet ends the data stage
      end
    end
  end

  // read sends until a short packet, the status stages send one zlp
  always_comb begin
    o_et0.valid  = (i_flags.read && !lastSent) || i_flags.noData || i_flags.write;
    o_et0.data   = slice;
    o_et0.nBytes = '0;
    if (i_flags.read) begin
      o_et0.nBytes = fullPkt ? NBYTES_W'(MAX_PKT) : remaining[NBYTES_W-1:0];
    end
  end

  pktCntBound: assert property (@(posedge i_clk) disable iff (!i_rstN)
    pktCnt <= 3'd4);

endmodule

/* deviceAddress.sv */
module deviceAddress import usbCtrlPkg::*; (
  input  logic       i_clk,
  input  logic       i_rstN,
  input  tfrFlags_t  i_flags,
  input  reqInfo_t   i_req,
  input  logic       i_statusDone,
  output logic [6:0] o_devAddr
);

  logic [6:0] pendingAddr;
  logic       appliedQ;

  // grab the new address while its no-data transfer runs
  always_ff @(posedge i_clk) begin
    if (i_flags.noData && i_req.isSetAddress) begin
      pendingAddr <= i_req.newAddr;
    end
  end

  // status IN must go out from the old address first
  always_ff @(posedge i_clk or negedge i_rstN) begin
    if (!i_rstN) begin
      appliedQ <= 1'b0;
    end else if (i_statusDone && i_req.isSetAddress) begin
      appliedQ <= 1'b1;   // sticky until reset
    end
  end

  assign o_devAddr = appliedQ ? pendingAddr : '0; // default address until applied

endmodule

/* usbCtrlSerial.sv */
module usbCtrlSerial import usbCtrlPkg::*; (
  input  logic                i_clk,
  input  logic                i_rstN,
  input  txnType_t            i_txnType,    // {setup, out, in}
  input  logic                i_er0Valid,
  input  logic [DATA_W-1:0]   i_er0Data,
  input  logic [NBYTES_W-1:0] i_er0NBytes,
  output logic                o_er0Ready,
  output logic                o_er0Stall,
  input  logic                i_et0Ready,   // ACK from host
  output logic                o_et0Valid,
  output logic [DATA_W-1:0]   o_et0Data,
  output logic [NBYTES_W-1:0] o_et0NBytes,
  output logic                o_et0Stall,
  output logic [6:0]          o_devAddr
);

  epRx_t     er0;
  epTx_t     et0;
  tfrFlags_t flags;
  reqInfo_t  req;
  logic      beginTfr;
  logic      statusDone;

  // bus side delivers plain bytes
  always_comb begin
    er0.valid      = i_er0Valid;
    er0.data.bytes = i_er0Data;
    er0.nBytes     = i_er0NBytes;
  end

  ctrlStageTracker uTracker (
    .i_clk        (i_clk),
    .i_rstN       (i_rstN),
    .i_txnType    (i_txnType),
    .i_er0        (er0),
    .i_et0Ready   (i_et0Ready),
    .i_et0        (et0),
    .o_er0Ready   (o_er0Ready),
    .o_er0Stall   (o_er0Stall),
    .o_et0Stall   (o_et0Stall),
    .o_begin      (beginTfr),
    .o_statusDone (statusDone),
    .o_flags      (flags),
    .o_req        (req)
  );

  descriptorSender uSender (
    .i_clk      (i_clk),
    .i_rstN     (i_rstN),
    .i_begin    (beginTfr),
    .i_flags    (flags),
    .i_req      (req),
    .i_et0Ready (i_et0Ready),
    .o_et0      (et0)
  );

  deviceAddress uDevAddr (
    .i_clk        (i_clk),
    .i_rstN       (i_rstN),
    .i_flags      (flags),
    .i_req        (req),
    .i_statusDone (statusDone),
    .o_devAddr    (o_devAddr)
  );

  assign o_et0Valid  = et0.valid;
  assign o_et0Data   = et0.data;
  assign o_et0NBytes = et0.nBytes;

endmodule

/* tb_usbCtrlSerial.sv */
module tb_usbCtrlSerial import usbCtrlPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 2000; // all tests take about 250 cycles
  localparam int WAIT_LIMIT     = 16;   // cycles allowed for an IN packet to show up

  logic                clk;
  logic                rstN;
  txnType_t            txnType;
  logic                er0Valid;
  logic [DATA_W-1:0]   er0Data;
  logic [NBYTES_W-1:0] er0NBytes;
  logic                er0Ready;
  logic                er0Stall;
  logic                et0Ready;
  logic                et0Valid;
  logic [DATA_W-1:0]   et0Data;
  logic [NBYTES_W-1:0] et0NBytes;
  logic                et0Stall;
  logic [6:0]          devAddr;

  logic [7:0] devTable [0:17];  // device descriptor as sent on the wire
  logic [7:0] cfgTable [0:31];  // config, interface, two endpoints
  int         errCount   = 0;
  int         checkCount = 0;
  int         cycleCount = 0;

  usbCtrlSerial u_usbCtrlSerial (
    .i_clk       (clk),
    .i_rstN      (rstN),
    .i_txnType   (txnType),
    .i_er0Valid  (er0Valid),
    .i_er0Data   (er0Data),
    .i_er0NBytes (er0NBytes),
    .o_er0Ready  (er0Ready),
    .o_er0Stall  (er0Stall),
    .i_et0Ready  (et0Ready),
    .o_et0Valid  (et0Valid),
    .o_et0Data   (et0Data),
    .o_et0NBytes (et0NBytes),
    .o_et0Stall  (et0Stall),
    .o_devAddr   (devAddr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("run stopped, tests still busy after %0d cycles", cycleCount);
      $display("checks: %0d, errors: %0d", checkCount, errCount);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic buildTables();
    devTable = '{8'd18, DESC_DEVICE, 8'h00, 8'h02,            // bcdUSB 2.00
                 CLASS_UNKNOWN, 8'h00, 8'h00, 8'(MAX_PKT),
                 VENDOR_ID[7:0], VENDOR_ID[15:8],
                 PRODUCT_ID[7:0], PRODUCT_ID[15:8],
                 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01};   // one configuration
    cfgTable = '{8'd9, DESC_CONFIG, 8'd32, 8'h00, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,
                 8'd9, DESC_INTERFACE, 8'd0, 8'd0, 8'd2, CLASS_VENDOR, 8'd0, 8'd0, 8'd0,
                 8'd7, DESC_ENDPOINT, 8'h81, EP_BULK, 8'(MAX_PKT), 8'h00, 8'd0,
                 8'd7, DESC_ENDPOINT, 8'h01, EP_BULK, 8'(MAX_PKT), 8'h00, 8'd0};
  endtask

  task automatic checkVal(input logic [63:0] got, input logic [63:0] exp,
                          input string what);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %0d ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic stepClk();
    @(posedge clk);
    #1;                         // drive just after the edge
  endtask

  task automatic idleInputs();
    txnType   = '0;
    er0Valid  = 1'b0;
    er0Data   = '0;
    er0NBytes = '0;
    et0Ready  = 1'b0;
  endtask

  task automatic sendSetup(input logic [7:0] bmReqType, input logic [7:0] bRequest,
                           input logic [15:0] wValue, input logic [15:0] wLength);
    txnType.setup = 1'b1;
    er0Valid      = 1'b1;
    er0NBytes     = 4'd8;
    er0Data       = {wLength, 16'h0000, wValue, bRequest, bmReqType}; // byte 0 lowest
    @(negedge clk);
    checkVal(64'(er0Ready), 64'd1, "setup not acked");
    stepClk();
    idleInputs();
  endtask

  task automatic sendZlpOut();
    txnType.out = 1'b1;         // status stage of a read
    er0Valid    = 1'b1;
    er0NBytes   = '0;
    @(negedge clk);
    checkVal(64'(er0Ready), 64'd1, "status OUT not acked");
    stepClk();
    idleInputs();
  endtask

  task automatic waitValid(input string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!et0Valid && waited < WAIT_LIMIT) begin
      stepClk();
      @(negedge clk);
      waited++;
    end
    if (!et0Valid) begin
      errCount++;
      $display("no IN packet offered within %0d cycles during %s", WAIT_LIMIT, what);
    end
  endtask

  task automatic readPacket(input logic descDev, input int offset, input int expN,
                            input int holdCycles);
    logic [DATA_W-1:0]   expData;
    logic [DATA_W-1:0]   mask;
    logic [DATA_W-1:0]   heldData;
    logic [NBYTES_W-1:0] heldN;
    expData = '0;
    mask    = '0;
    for (int b = 0; b < expN; b++) begin
      expData[8*b +: 8] = descDev ? devTable[offset + b] : cfgTable[offset + b];
      mask[8*b +: 8]    = 8'hff;    // only the bytes the packet carries
    end
    txnType.in = 1'b1;
    waitValid("descriptor read");
    checkVal(64'(et0NBytes), 64'(expN), "IN packet byte count");
    checkVal(et0Data & mask, expData, "IN packet data");
    heldData = et0Data;
    heldN    = et0NBytes;
    repeat (holdCycles) begin       // host NAKs, ready stays low
      stepClk();
      @(negedge clk);
      checkVal(64'(et0Valid), 64'd1, "valid dropped under back-pressure");
      checkVal(et0Data, heldData, "data moved under back-pressure");
      checkVal(64'(et0NBytes), 64'(heldN), "count moved under back-pressure");
    end
    stepClk();
    et0Ready = 1'b1;                // host ACK
    stepClk();
    idleInputs();
  endtask

  task automatic acceptZlpIn(input logic [6:0] newAddr);
    txnType.in = 1'b1;
    waitValid("status stage");
    checkVal(64'(et0NBytes), 64'd0, "status IN not zero length");
    checkVal(64'(devAddr), 64'd0, "address applied before status IN");
    stepClk();
    et0Ready = 1'b1;
    @(negedge clk);
    checkVal(64'(devAddr), 64'd0, "address applied during status IN");
    stepClk();
    idleInputs();
    @(negedge clk);
    checkVal(64'(devAddr), 64'(newAddr), "address not applied after status IN");
    checkVal(64'(et0Valid), 64'd0, "IN still offered after status stage");
    stepClk();
  endtask

  task automatic readDescriptor(input logic descDev, input int wLength,
                                input int holdFirst);
    int descLen;
    int n;
    int sent;
    int cnt;
    descLen = descDev ? $size(devTable) : $size(cfgTable);
    n       = (wLength < descLen) ? wLength : descLen;  // host may ask for less
    sent    = 0;
    sendSetup(8'h80, REQ_GET_DESCRIPTOR, {descDev ? DESC_DEVICE : DESC_CONFIG, 8'h00},
              16'(wLength));
    @(negedge clk);
    checkVal(64'(et0Stall), 64'd0, "IN stall on a supported read");
    checkVal(64'(er0Stall), 64'd0, "OUT stall on a supported read");
    stepClk();
    do begin                        // short or empty packet ends the data stage
      cnt = (n - sent >= MAX_PKT) ? MAX_PKT : n - sent;
      readPacket(descDev, sent, cnt, (sent == 0) ? holdFirst : 0);
      sent += cnt;
    end while (cnt == MAX_PKT);
    @(negedge clk);
    checkVal(64'(et0Valid), 64'd0, "IN offered after the last data packet");
    stepClk();
    sendZlpOut();
    repeat (3) begin
      @(negedge clk);
      checkVal(64'(et0Valid), 64'd0, "IN offered after the status stage");
      checkVal(64'(er0Ready), 64'd0, "read stage still open after status OUT");
      stepClk();
    end
  endtask

  task automatic verifyResetState();
    @(negedge clk);
    checkVal(64'(et0Valid), 64'd0, "valid after reset");
    checkVal(64'(et0Stall), 64'd0, "IN stall after reset");
    checkVal(64'(er0Stall), 64'd0, "OUT stall after reset");
    checkVal(64'(devAddr), 64'd0, "address after reset");
    stepClk();
  endtask

  task automatic readConfigSet();
    readDescriptor(1'b0, 9, 0);     // header only, 8 + 1
    readDescriptor(1'b0, 255, 5);   // whole set, trailing zlp
  endtask

  task automatic stallStringRequest();
    sendSetup(8'h80, REQ_GET_DESCRIPTOR, 16'h0300, 16'd255); // string index 0
    repeat (3) begin
      @(negedge clk);
      checkVal(64'(et0Stall), 64'd1, "string request not stalled");
      checkVal(64'(et0Valid), 64'd0, "valid high while stalled");
      stepClk();
    end
    readDescriptor(1'b1, 18, 0);    // its setup clears the stall
  endtask

  task automatic stallWriteRequest();
    sendSetup(8'h00, 8'd7, 16'h0100, 16'd4); // SET_DESCRIPTOR with data
    @(negedge clk);
    checkVal(64'(er0Stall), 64'd1, "write request not stalled");
    checkVal(64'(et0Stall), 64'd0, "IN stall on a write request");
    checkVal(64'(et0Valid), 64'd0, "valid high while stalled");
    stepClk();
  endtask

  task automatic setAddressThenRead();
    sendSetup(8'h00, REQ_SET_ADDRESS, 16'd42, 16'd0);
    @(negedge clk);
    checkVal(64'(er0Stall), 64'd0, "OUT stall kept past a new setup");
    stepClk();
    acceptZlpIn(7'd42);
    readDescriptor(1'b1, 64, 0);
    readDescriptor(1'b0, 255, 0);
    @(negedge clk);
    checkVal(64'(devAddr), 64'd42, "address lost after later reads");
    stepClk();
  endtask

  initial begin
    rstN = 1'b0;
    idleInputs();
    buildTables();
    repeat (3) @(posedge clk);      // reset for 3 cycles
    #1;
    rstN = 1'b1;
    verifyResetState();
    readDescriptor(1'b1, 64, 0);    // 8, 8, 2
    readConfigSet();
    stallStringRequest();
    stallWriteRequest();
    setAddressThenRead();
    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tb.f */
usbCtrlPkg.sv
ctrlStageTracker.sv
descriptorRom.sv
descriptorSender.sv
deviceAddress.sv
usbCtrlSerial.sv
tb_usbCtrlSerial.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_usbCtrlSerial -o simTb \
  && { ./obj_dir/simTb > sim.log 2>&1; cat sim.log; } \
  || { echo "build failed"; exit 1; }

grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no verdict in log"; exit 1; }
echo "simulation passed"
exit 0
